//--- flist.f
common/prf_geom_pkg.sv
common/prf_port_pkg.sv
hdl/prf_pick.sv
hdl/prf_release.sv
prf_store/prf_entry.sv
prf_store/prf_entry_array.sv
hdl/prf.sv
sim/prf_clkgen.sv
sim/prf_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module prf_tb -f flist.f -o prf_sim

run: build
	@obj_dir/prf_sim > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "SOME TESTS FAILED" $(LOG); then exit 1; fi; exit $$status

lint:
	verilator --lint-only -Wall --timing --top-module prf_tb -f flist.f

clean:
	rm -rf obj_dir $(LOG)

//--- sim/prf_tb.sv
`default_nettype none

module prf_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import prf_geom_pkg::*;

	localparam int n_rows       = 30; // rows in the step table below
	localparam int reset_cycles = 3;
	localparam int n_data       = 8;  // random cdb payloads the table points into

	logic                  clock;
	logic                  arst_n;
	logic                  rat1_alloc;
	logic                  rat2_alloc;
	logic                  rat1_rename_valid;
	logic [prf_idx_w-1:0]  rat1_rename_idx;
	logic                  rat2_rename_valid;
	logic [prf_idx_w-1:0]  rat2_rename_idx;
	logic                  rrat1_free_valid;
	logic [prf_idx_w-1:0]  rrat1_free_idx;
	logic                  rrat2_free_valid;
	logic [prf_idx_w-1:0]  rrat2_free_idx;
	logic                  rrat1_flush;
	logic                  rrat2_flush;
	logic [prf_size-1:0]   lists [4];   // rrat1, rrat2, rat1, rat2 free lists
	logic                  cdb1_valid;
	logic [prf_idx_w-1:0]  cdb1_tag;
	logic [prf_data_w-1:0] cdb1_data;
	logic                  cdb2_valid;
	logic [prf_idx_w-1:0]  cdb2_tag;
	logic [prf_data_w-1:0] cdb2_data;
	logic [prf_idx_w-1:0]  rd_idx [4];  // inst1 opa, inst1 opb, inst2 opa, inst2 opb
	logic [prf_data_w-1:0] rd_value [4];
	logic                  rd_valid [4];

	string rd_port [4] = '{"inst1_opa", "inst1_opb", "inst2_opa", "inst2_opb"};
	string test_name [7] = '{"", "after reset", "allocation order", "writeback",
		"retirement release", "mispredict release", "writes to free entries"};

	//////////////////////////////////////////////////////////////////////
	// step table with one row per clock cycle
	//////////////////////////////////////////////////////////////////////

	int                  test_of  [n_rows]; // behavior number the row belongs to
	bit                  req1_q   [n_rows];
	bit                  req2_q   [n_rows];
	int                  exp1_q   [n_rows]; // expected rename index or -1 for no grant
	int                  exp2_q   [n_rows];
	int                  cdb1_q   [n_rows]; // writeback tag where -1 leaves the bus idle
	int                  cdb2_q   [n_rows];
	int                  dat1_q   [n_rows]; // index into data_tab
	int                  dat2_q   [n_rows];
	int                  ret1_q   [n_rows]; // retired index or -1 for none
	int                  ret2_q   [n_rows];
	bit                  fl1_q    [n_rows];
	bit                  fl2_q    [n_rows];
	logic [prf_size-1:0] lists_q  [n_rows][4];
	int                  rd_q     [n_rows][4];
	int                  exp_rd_q [n_rows][4]; // data_tab index with -1 not valid and -2 unchecked
	logic [prf_data_w-1:0] data_tab [n_data];
	int                  nr;       // rows filled so far
	int                  seed;
	int                  checks;
	int                  errors;
	int                  tests;
	int                  test_errs; // error count when the current test began

	prf_clkgen #(.reset_cycles(reset_cycles)) i_clkgen (
		.clock (clock),
		.arst_n(arst_n)
	);

	prf i_prf (
		.clock            (clock),
		.arst_n           (arst_n),
		.rat1_alloc       (rat1_alloc),
		.rat2_alloc       (rat2_alloc),
		.rat1_rename_valid(rat1_rename_valid),
		.rat1_rename_idx  (rat1_rename_idx),
		.rat2_rename_valid(rat2_rename_valid),
		.rat2_rename_idx  (rat2_rename_idx),
		.rrat1_free_valid (rrat1_free_valid),
		.rrat1_free_idx   (rrat1_free_idx),
		.rrat2_free_valid (rrat2_free_valid),
		.rrat2_free_idx   (rrat2_free_idx),
		.rrat1_flush      (rrat1_flush),
		.rrat2_flush      (rrat2_flush),
		.rrat1_free_list  (lists[0]),
		.rrat2_free_list  (lists[1]),
		.rat1_free_list   (lists[2]),
		.rat2_free_list   (lists[3]),
		.cdb1_valid       (cdb1_valid),
		.cdb1_tag         (cdb1_tag),
		.cdb1_data        (cdb1_data),
		.cdb2_valid       (cdb2_valid),
		.cdb2_tag         (cdb2_tag),
		.cdb2_data        (cdb2_data),
		.inst1_opa_idx    (rd_idx[0]),
		.inst1_opb_idx    (rd_idx[1]),
		.inst2_opa_idx    (rd_idx[2]),
		.inst2_opb_idx    (rd_idx[3]),
		.inst1_opa_value  (rd_value[0]),
		.inst1_opb_value  (rd_value[1]),
		.inst2_opa_value  (rd_value[2]),
		.inst2_opb_value  (rd_value[3]),
		.inst1_opa_valid  (rd_valid[0]),
		.inst1_opb_valid  (rd_valid[1]),
		.inst2_opa_valid  (rd_valid[2]),
		.inst2_opb_valid  (rd_valid[3])
	);

	// a new row is idle apart from its rename requests
	task automatic add_row(input int test, input bit req1, input bit req2,
		input int exp1, input int exp2);
		if (nr >= n_rows)
		begin
			$display("step table is full, row for test %0d dropped", test);
			errors++;
			return;
		end
		test_of[nr] = test;
		req1_q[nr]  = req1;
		req2_q[nr]  = req2;
		exp1_q[nr]  = exp1;
		exp2_q[nr]  = exp2;
		cdb1_q[nr]  = -1;
		cdb2_q[nr]  = -1;
		dat1_q[nr]  = 0;
		dat2_q[nr]  = 0;
		ret1_q[nr]  = -1;
		ret2_q[nr]  = -1;
		fl1_q[nr]   = 1'b0;
		fl2_q[nr]   = 1'b0;
		for (int k = 0; k < 4; k++)
		begin
			lists_q[nr][k]  = '0;
			rd_q[nr][k]     = k;
			exp_rd_q[nr][k] = -2; // reads are left unchecked unless a row says otherwise
		end
		nr++;
	endtask

	// the modifiers below fill in the row added last
	task automatic cdb_writes(input int tag1, input int dat1, input int tag2, input int dat2);
		cdb1_q[nr-1] = tag1;
		dat1_q[nr-1] = dat1;
		cdb2_q[nr-1] = tag2;
		dat2_q[nr-1] = dat2;
	endtask

	task automatic retire_frees(input int idx1, input int idx2);
		ret1_q[nr-1] = idx1;
		ret2_q[nr-1] = idx2;
	endtask

	task automatic flush_lists(input bit fl1, input bit fl2, input logic [prf_size-1:0] l0,
		input logic [prf_size-1:0] l1, input logic [prf_size-1:0] l2,
		input logic [prf_size-1:0] l3);
		fl1_q[nr-1]      = fl1;
		fl2_q[nr-1]      = fl2;
		lists_q[nr-1][0] = l0;
		lists_q[nr-1][1] = l1;
		lists_q[nr-1][2] = l2;
		lists_q[nr-1][3] = l3;
	endtask

	task automatic operand_reads(input int r0, input int r1, input int r2, input int r3,
		input int e0, input int e1, input int e2, input int e3);
		rd_q[nr-1]     = '{r0, r1, r2, r3};
		exp_rd_q[nr-1] = '{e0, e1, e2, e3};
	endtask

	// expected values follow the entry rules
	// free beats alloc and alloc beats write
	// a read is valid only on a ready entry that is not available
	task automatic build_table();
		add_row(1, 1, 1, 0, 1); // whole file free out of reset
		operand_reads(0, 1, 2, 3, -1, -1, -1, -1);
		for (int k = 1; k < 15; k++)
		begin
			add_row(2, 1, 1, 2 * k, 2 * k + 1); // entries 2 to 29 in pairs
		end
		add_row(2, 1, 0, 30, -1);
		add_row(2, 1, 1, 31, -1);             // last entry goes to rat1
		add_row(2, 1, 1, -1, -1);             // pool is empty
		add_row(3, 0, 0, -1, -1);
		cdb_writes(5, 0, 9, 1);
		operand_reads(5, 9, 5, 9, -1, -1, -1, -1); // no bypass from the cdb
		add_row(3, 0, 0, -1, -1);
		cdb_writes(12, 2, 20, 3);
		operand_reads(5, 9, 9, 5, 0, 1, 1, 0);
		add_row(3, 0, 0, -1, -1);
		operand_reads(12, 20, 7, 5, 2, 3, -1, 0); // 7 is allocated but never written
		add_row(4, 0, 0, -1, -1);
		retire_frees(5, 12);
		operand_reads(5, 12, 9, 20, 0, 2, 1, 3);  // still readable until the edge
		add_row(4, 1, 1, 5, 12);                  // released entries are the lowest free
		operand_reads(5, 12, 9, 20, -1, -1, 1, 3);
		add_row(4, 0, 0, -1, -1);
		operand_reads(5, 12, 9, 20, -1, -1, 1, 3);
		add_row(5, 0, 0, -1, -1);
		cdb_writes(3, 4, -1, 0);
		operand_reads(3, 9, 20, 25, -1, 1, 3, -1);
		// rrat1 list {3,9,20,25} and rat2 list {9,25,30} leave {9,25}
		add_row(5, 0, 0, -1, -1);
		flush_lists(1, 0, 32'h0210_0208, '1, '1, 32'h4200_0200);
		operand_reads(3, 9, 20, 25, 4, 1, 3, -1);
		add_row(5, 0, 0, -1, -1);
		operand_reads(3, 9, 20, 25, 4, -1, 3, -1);
		add_row(6, 0, 0, -1, -1);
		cdb_writes(9, 5, -1, 0);                  // 9 sits in the pool so the write is dropped
		operand_reads(9, 25, 3, 20, -1, -1, 4, 3);
		add_row(6, 1, 1, 9, 25);
		operand_reads(9, 25, 3, 20, -1, -1, 4, 3);
		add_row(6, 1, 1, -1, -1);                 // the flush put nothing else back in the pool
		operand_reads(9, 25, 3, 20, -1, -1, 4, 3);
	endtask

	//////////////////////////////////////////////////////////////////////
	// driving and checking
	//////////////////////////////////////////////////////////////////////

	task automatic check(input string sig, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("mismatch at %0t: %s expected %h got %h", $time, sig, exp, act);
		end
	endtask

	task automatic drive_row(input int r);
		rat1_alloc       <= req1_q[r];
		rat2_alloc       <= req2_q[r];
		cdb1_valid       <= cdb1_q[r] >= 0;
		cdb1_tag         <= prf_idx_w'(cdb1_q[r]); // an idle bus carries tag 31 which nobody reads
		cdb1_data        <= data_tab[dat1_q[r]];
		cdb2_valid       <= cdb2_q[r] >= 0;
		cdb2_tag         <= prf_idx_w'(cdb2_q[r]);
		cdb2_data        <= data_tab[dat2_q[r]];
		rrat1_free_valid <= ret1_q[r] >= 0;
		rrat1_free_idx   <= prf_idx_w'(ret1_q[r]);
		rrat2_free_valid <= ret2_q[r] >= 0;
		rrat2_free_idx   <= prf_idx_w'(ret2_q[r]);
		rrat1_flush      <= fl1_q[r];
		rrat2_flush      <= fl2_q[r];
		for (int k = 0; k < 4; k++)
		begin
			lists[k]  <= lists_q[r][k];
			rd_idx[k] <= prf_idx_w'(rd_q[r][k]);
		end
	endtask

	task automatic check_row(input int r);
		int e;
		check("rat1_rename_valid", 64'(exp1_q[r] >= 0), 64'(rat1_rename_valid));
		if (exp1_q[r] >= 0)
		begin
			check("rat1_rename_idx", 64'(exp1_q[r]), 64'(rat1_rename_idx));
		end
		check("rat2_rename_valid", 64'(exp2_q[r] >= 0), 64'(rat2_rename_valid));
		if (exp2_q[r] >= 0)
		begin
			check("rat2_rename_idx", 64'(exp2_q[r]), 64'(rat2_rename_idx));
		end
		for (int p = 0; p < 4; p++)
		begin
			e = exp_rd_q[r][p];
			if (e >= -1)
			begin
				check({rd_port[p], "_valid"}, 64'(e >= 0), 64'(rd_valid[p]));
				check({rd_port[p], "_value"}, (e >= 0) ? data_tab[e] : '0, rd_value[p]);
			end
		end
	endtask

	initial
	begin
		checks = 0;
		errors = 0;
		tests  = 0;
		nr     = 0;
		seed   = 32'hd8be;
		for (int k = 0; k < n_data; k++)
		begin
			data_tab[k] = {$random(seed), $random(seed)};
		end
		build_table();
		if (nr != n_rows)
		begin
			$display("step table holds %0d rows instead of %0d", nr, n_rows);
			errors++;
		end

		rat1_alloc       = 1'b0;
		rat2_alloc       = 1'b0;
		rrat1_free_valid = 1'b0;
		rrat1_free_idx   = '0;
		rrat2_free_valid = 1'b0;
		rrat2_free_idx   = '0;
		rrat1_flush      = 1'b0;
		rrat2_flush      = 1'b0;
		cdb1_valid       = 1'b0;
		cdb1_tag         = '0;
		cdb1_data        = '0;
		cdb2_valid       = 1'b0;
		cdb2_tag         = '0;
		cdb2_data        = '0;
		for (int k = 0; k < 4; k++)
		begin
			lists[k]  = '0;
			rd_idx[k] = '0;
		end

		@(posedge arst_n);
		for (int r = 0; r < nr; r++)
		begin
			if (r == 0 || test_of[r] != test_of[r-1])
			begin
				test_errs = errors;
			end
			@(posedge clock);
			drive_row(r);
			@(negedge clock); // combinational outputs have settled here
			check_row(r);
			if (r == nr - 1 || test_of[r+1] != test_of[r])
			begin
				tests++;
				$display("test %0d %s: %0d errors", test_of[r], test_name[test_of[r]],
					errors - test_errs);
			end
		end

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
		begin
			$display("ALL TESTS PASSED");
		end
		else
		begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	// one cycle per row plus reset and some slack
	initial
	begin
		#((n_rows + reset_cycles + 10) * 20);
		$display("watchdog expired before the step table was done");
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/prf_clkgen.sv
`default_nettype none

// free running testbench clock and power-on reset
module prf_clkgen #(
	parameter int reset_cycles = 3
) (
	output logic clock,
	output logic arst_n
);
	timeunit 1ns;
	timeprecision 1ps;

	initial
	begin
		clock = 1'b0;
		forever #10 clock = ~clock; // 20 ns period
	end

	initial
	begin
		arst_n = 1'b0;
		repeat (reset_cycles) @(posedge clock);
		@(negedge clock);
		arst_n <= 1'b1; // release half a cycle away from the rising edge
	end

endmodule

`default_nettype wire

//--- hdl/prf.sv
`default_nettype none

module prf (
	input  wire                                clock,
	input  wire                                arst_n,

	// rename side
	input  wire                                rat1_alloc,
	input  wire                                rat2_alloc,
	output logic                               rat1_rename_valid,
	output logic [prf_geom_pkg::prf_idx_w-1:0]  rat1_rename_idx,
	output logic                               rat2_rename_valid,
	output logic [prf_geom_pkg::prf_idx_w-1:0]  rat2_rename_idx,

	// retirement and mispredict release
	input  wire                                rrat1_free_valid,
	input  wire  [prf_geom_pkg::prf_idx_w-1:0]  rrat1_free_idx,
	input  wire                                rrat2_free_valid,
	input  wire  [prf_geom_pkg::prf_idx_w-1:0]  rrat2_free_idx,
	input  wire                                rrat1_flush,
	input  wire                                rrat2_flush,
	input  wire  [prf_geom_pkg::prf_size-1:0]   rrat1_free_list,
	input  wire  [prf_geom_pkg::prf_size-1:0]   rrat2_free_list,
	input  wire  [prf_geom_pkg::prf_size-1:0]   rat1_free_list,
	input  wire  [prf_geom_pkg::prf_size-1:0]   rat2_free_list,

	// writeback
	input  wire                                cdb1_valid,
	input  wire  [prf_geom_pkg::prf_idx_w-1:0]  cdb1_tag,
	input  wire  [prf_geom_pkg::prf_data_w-1:0] cdb1_data,
	input  wire                                cdb2_valid,
	input  wire  [prf_geom_pkg::prf_idx_w-1:0]  cdb2_tag,
	input  wire  [prf_geom_pkg::prf_data_w-1:0] cdb2_data,

	// operand reads
	input  wire  [prf_geom_pkg::prf_idx_w-1:0]  inst1_opa_idx,
	input  wire  [prf_geom_pkg::prf_idx_w-1:0]  inst1_opb_idx,
	input  wire  [prf_geom_pkg::prf_idx_w-1:0]  inst2_opa_idx,
	input  wire  [prf_geom_pkg::prf_idx_w-1:0]  inst2_opb_idx,
	output logic [prf_geom_pkg::prf_data_w-1:0] inst1_opa_value,
	output logic [prf_geom_pkg::prf_data_w-1:0] inst1_opb_value,
	output logic [prf_geom_pkg::prf_data_w-1:0] inst2_opa_value,
	output logic [prf_geom_pkg::prf_data_w-1:0] inst2_opb_value,
	output logic                               inst1_opa_valid,
	output logic                               inst1_opb_valid,
	output logic                               inst2_opa_valid,
	output logic                               inst2_opb_valid
);

	import prf_geom_pkg::*;
	import prf_port_pkg::*;

	logic [prf_size-1:0] available_vec;
	logic [prf_size-1:0] grant [prf_n_rename]; // one per rename table, rat1 first
	logic [prf_size-1:0] rat2_req;            // pool left over once rat1 has picked
	logic [prf_size-1:0] alloc_vec;
	logic [prf_size-1:0] free_vec;

	//////////////////////////////////////////////////////////////////////
	// allocation
	//////////////////////////////////////////////////////////////////////

	prf_pick #(.width(prf_size)) i_pick_rat1 (
		.req  (available_vec),
		.en   (rat1_alloc),
		.gnt  (grant[0]),
		.valid(rat1_rename_valid),
		.idx  (rat1_rename_idx)
	);

	// rat2 takes the lowest entry that rat1 did not take this cycle
	assign rat2_req = available_vec & ~grant[0];

	prf_pick #(.width(prf_size)) i_pick_rat2 (
		.req  (rat2_req),
		.en   (rat2_alloc),
		.gnt  (grant[1]),
		.valid(rat2_rename_valid),
		.idx  (rat2_rename_idx)
	);

	always_comb
	begin
		alloc_vec = '0;
		for (int p = 0; p < prf_n_rename; p++)
		begin
			alloc_vec = alloc_vec | grant[p];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// release and storage
	//////////////////////////////////////////////////////////////////////

	prf_release i_release (
		.rrat1_free_valid(rrat1_free_valid),
		.rrat1_free_idx  (rrat1_free_idx),
		.rrat2_free_valid(rrat2_free_valid),
		.rrat2_free_idx  (rrat2_free_idx),
		.rrat1_flush     (rrat1_flush),
		.rrat2_flush     (rrat2_flush),
		.rrat1_free_list (rrat1_free_list),
		.rrat2_free_list (rrat2_free_list),
		.rat1_free_list  (rat1_free_list),
		.rat2_free_list  (rat2_free_list),
		.free_vec        (free_vec)
	);

	prf_entry_array i_array (
		.clock          (clock),
		.arst_n         (arst_n),
		.alloc_vec      (alloc_vec),
		.free_vec       (free_vec),
		.cdb1_valid     (cdb1_valid),
		.cdb1_tag       (cdb1_tag),
		.cdb1_data      (cdb1_data),
		.cdb2_valid     (cdb2_valid),
		.cdb2_tag       (cdb2_tag),
		.cdb2_data      (cdb2_data),
		.inst1_opa_idx  (inst1_opa_idx),
		.inst1_opb_idx  (inst1_opb_idx),
		.inst2_opa_idx  (inst2_opa_idx),
		.inst2_opb_idx  (inst2_opb_idx),
		.available_vec  (available_vec),
		.inst1_opa_value(inst1_opa_value),
		.inst1_opb_value(inst1_opb_value),
		.inst2_opa_value(inst2_opa_value),
		.inst2_opb_value(inst2_opb_value),
		.inst1_opa_valid(inst1_opa_valid),
		.inst1_opb_valid(inst1_opb_valid),
		.inst2_opa_valid(inst2_opa_valid),
		.inst2_opb_valid(inst2_opb_valid)
	);

endmodule

`default_nettype wire

//--- prf_store/prf_entry_array.sv
`default_nettype none

module prf_entry_array (
	input  wire                                clock,
	input  wire                                arst_n,
	input  wire  [prf_geom_pkg::prf_size-1:0]   alloc_vec, // grants of both pickers
	input  wire  [prf_geom_pkg::prf_size-1:0]   free_vec,  // from the release block
	input  wire                                cdb1_valid,
	input  wire  [prf_geom_pkg::prf_idx_w-1:0]  cdb1_tag,
	input  wire  [prf_geom_pkg::prf_data_w-1:0] cdb1_data,
	input  wire                                cdb2_valid,
	input  wire  [prf_geom_pkg::prf_idx_w-1:0]  cdb2_tag,
	input  wire  [prf_geom_pkg::prf_data_w-1:0] cdb2_data,
	input  wire  [prf_geom_pkg::prf_idx_w-1:0]  inst1_opa_idx,
	input  wire  [prf_geom_pkg::prf_idx_w-1:0]  inst1_opb_idx,
	input  wire  [prf_geom_pkg::prf_idx_w-1:0]  inst2_opa_idx,
	input  wire  [prf_geom_pkg::prf_idx_w-1:0]  inst2_opb_idx,
	output logic [prf_geom_pkg::prf_size-1:0]   available_vec,
	output logic [prf_geom_pkg::prf_data_w-1:0] inst1_opa_value,
	output logic [prf_geom_pkg::prf_data_w-1:0] inst1_opb_value,
	output logic [prf_geom_pkg::prf_data_w-1:0] inst2_opa_value,
	output logic [prf_geom_pkg::prf_data_w-1:0] inst2_opb_value,
	output logic                               inst1_opa_valid,
	output logic                               inst1_opb_valid,
	output logic                               inst2_opa_valid,
	output logic                               inst2_opb_valid
);

	import prf_geom_pkg::*;
	import prf_port_pkg::*;

	logic [prf_size-1:0]   alloc_take;            // allocation after release had its say
	logic [prf_size-1:0]   ready_vec;
	logic [prf_size-1:0]   wr_en;
	logic [prf_data_w-1:0] wr_data    [prf_size];
	logic [prf_data_w-1:0] entry_data [prf_size];
	logic                  cdb_valid  [prf_n_cdb];
	logic [prf_idx_w-1:0]  cdb_tag    [prf_n_cdb];
	logic [prf_data_w-1:0] cdb_data   [prf_n_cdb];
	logic [prf_idx_w-1:0]  rd_idx     [prf_n_read];
	logic [prf_data_w-1:0] rd_value   [prf_n_read];
	logic                  rd_valid   [prf_n_read];

	//////////////////////////////////////////////////////////////////////
	// writeback decode
	//////////////////////////////////////////////////////////////////////

	assign cdb_valid[0] = cdb1_valid;
	assign cdb_tag[0]   = cdb1_tag;
	assign cdb_data[0]  = cdb1_data;
	assign cdb_valid[1] = cdb2_valid;
	assign cdb_tag[1]   = cdb2_tag;
	assign cdb_data[1]  = cdb2_data;

	always_comb
	begin
		for (int i = 0; i < prf_size; i++)
		begin
			wr_en[i]   = 1'b0;
			wr_data[i] = '0;
			// later buses overwrite earlier ones, so cdb2 wins a shared tag
			for (int j = 0; j < prf_n_cdb; j++)
			begin
				if (cdb_valid[j] && cdb_tag[j] == prf_idx_w'(i))
				begin
					wr_en[i]   = 1'b1;
					wr_data[i] = cdb_data[j];
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// entries
	//////////////////////////////////////////////////////////////////////

	// a release in the same cycle keeps the entry in the pool
	assign alloc_take = alloc_vec & ~free_vec;

	for (genvar i = 0; i < prf_size; i++)
	begin : g_entry
		prf_entry i_entry (
			.clock    (clock),
			.arst_n   (arst_n),
			.free     (free_vec[i]),
			.alloc    (alloc_take[i]),
			.write    (wr_en[i]),
			.data_in  (wr_data[i]),
			.available(available_vec[i]),
			.ready    (ready_vec[i]),
			.data_out (entry_data[i])
		);
	end

	//////////////////////////////////////////////////////////////////////
	// operand reads
	//////////////////////////////////////////////////////////////////////

	assign rd_idx[0] = inst1_opa_idx;
	assign rd_idx[1] = inst1_opb_idx;
	assign rd_idx[2] = inst2_opa_idx;
	assign rd_idx[3] = inst2_opb_idx;

	// no cdb bypass here, a writeback shows up one cycle after its strobe
	always_comb
	begin
		for (int r = 0; r < prf_n_read; r++)
		begin
			rd_valid[r] = ready_vec[rd_idx[r]] && !available_vec[rd_idx[r]];
			rd_value[r] = rd_valid[r] ? entry_data[rd_idx[r]] : '0; // stale data reads as zero
		end
	end

	assign inst1_opa_value = rd_value[0];
	assign inst1_opb_value = rd_value[1];
	assign inst2_opa_value = rd_value[2];
	assign inst2_opb_value = rd_value[3];
	assign inst1_opa_valid = rd_valid[0];
	assign inst1_opb_valid = rd_valid[1];
	assign inst2_opa_valid = rd_valid[2];
	assign inst2_opb_valid = rd_valid[3];

	// two producers for one tag means the rename logic handed it out twice
	a_cdb_tag_clash: assert property (@(posedge clock) disable iff (!arst_n)
		!(cdb1_valid && cdb2_valid && cdb1_tag == cdb2_tag))
		else $error("prf_entry_array: both cdbs write tag %0d", cdb1_tag);

	// the pickers only grant free entries, releasing one of them is a bookkeeping bug upstream
	a_alloc_free_overlap: assert property (@(posedge clock) disable iff (!arst_n)
		(alloc_vec & free_vec) == '0)
		else $error("prf_entry_array: alloc and free hit the same entry");

endmodule

`default_nettype wire

//--- prf_store/prf_entry.sv
`default_nettype none

// one physical register with its available and ready flags
// available high means the entry sits in the free pool
// ready high means the value has come back on a cdb
module prf_entry (
	input  wire                                clock,
	input  wire                                arst_n,
	input  wire                                free,      // release from retirement or mispredict
	input  wire                                alloc,     // handed out to a rename table
	input  wire                                write,     // cdb writeback aimed at this entry
	input  wire  [prf_geom_pkg::prf_data_w-1:0] data_in,
	output logic                               available,
	output logic                               ready,
	output logic [prf_geom_pkg::prf_data_w-1:0] data_out
);

	logic load; // a writeback that actually lands

	// free beats alloc, alloc beats write, and a free entry ignores writes
	assign load = write && !available && !free && !alloc;

	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			available <= 1'b1; // the whole file is free out of reset
			ready     <= 1'b0;
		end
		else if (free)
		begin
			available <= 1'b1;
			ready     <= 1'b0;
		end
		else if (alloc)
		begin
			available <= 1'b0;
			ready     <= 1'b0; // a new producer makes the old value stale
		end
		else if (load)
		begin
			ready <= 1'b1;
		end
	end

	// the data register loads only when a writeback lands
	always_ff @(posedge clock)
	begin
		if (load)
		begin
			data_out <= data_in;
		end
	end

	// a value can only become ready on an entry some rename table owns
	a_ready_owned: assert property (@(posedge clock) disable iff (!arst_n)
		available |-> !ready)
		else $error("prf_entry: ready set on an available entry");

endmodule

`default_nettype wire

//--- hdl/prf_release.sv
`default_nettype none

module prf_release (
	input  wire                               rrat1_free_valid, // retirement through rrat1
	input  wire  [prf_geom_pkg::prf_idx_w-1:0] rrat1_free_idx,
	input  wire                               rrat2_free_valid, // retirement through rrat2
	input  wire  [prf_geom_pkg::prf_idx_w-1:0] rrat2_free_idx,
	input  wire                               rrat1_flush,      // mispredict seen by rrat1
	input  wire                               rrat2_flush,      // mispredict seen by rrat2
	input  wire  [prf_geom_pkg::prf_size-1:0]  rrat1_free_list,
	input  wire  [prf_geom_pkg::prf_size-1:0]  rrat2_free_list,
	input  wire  [prf_geom_pkg::prf_size-1:0]  rat1_free_list,
	input  wire  [prf_geom_pkg::prf_size-1:0]  rat2_free_list,
	output logic [prf_geom_pkg::prf_size-1:0]  free_vec
);

	import prf_geom_pkg::*;
	import prf_port_pkg::*;

	logic                 rel_valid [prf_n_release];
	logic [prf_idx_w-1:0] rel_idx   [prf_n_release];

	assign rel_valid[0] = rrat1_free_valid;
	assign rel_idx[0]   = rrat1_free_idx;
	assign rel_valid[1] = rrat2_free_valid;
	assign rel_idx[1]   = rrat2_free_idx;

	always_comb
	begin
		free_vec = '0;

		// retirement frees the old mapping of the retired destination
		for (int p = 0; p < prf_n_release; p++)
		begin
			if (rel_valid[p])
			begin
				free_vec[rel_idx[p]] = 1'b1;
			end
		end

		// on a mispredict an entry goes back only if neither side still maps it
		// rrat1 is paired with rat2 because the other pipe keeps its own rename
		if (rrat1_flush)
		begin
			free_vec = rrat1_free_list & rat2_free_list;
		end
		if (rrat2_flush)
		begin
			free_vec = rrat2_free_list & rat1_free_list; // rrat2 has the last word
		end
	end

endmodule

`default_nettype wire

//--- hdl/prf_pick.sv
`default_nettype none

// lowest index first priority picker
// grant is one-hot or zero
// idx is only meaningful when valid is high
module prf_pick #(
	parameter int width = prf_geom_pkg::prf_size
) (
	input  wire  [width-1:0]         req,
	input  wire                      en,
	output logic [width-1:0]         gnt,
	output logic                     valid,
	output logic [$clog2(width)-1:0] idx
);

	localparam int idx_w = $clog2(width);

	always_comb
	begin
		gnt   = '0;
		idx   = '0;
		valid = 1'b0;
		if (en)
		begin
			for (int i = 0; i < width; i++)
			begin
				if (req[i] && !valid) // first hit stops further grants
				begin
					gnt[i] = 1'b1;
					idx    = idx_w'(i);
					valid  = 1'b1;
				end
			end
		end

		// a grant is a single bit taken out of the request
		a_gnt_legal: assert ($onehot0(gnt) && (gnt & ~req) == '0)
			else $error("prf_pick: grant %h is not a single bit of request %h", gnt, req);
	end

endmodule

`default_nettype wire

//--- common/prf_port_pkg.sv
`default_nettype none

// port counts of the register file
// the top level keeps every port loose, these size the internal loops
package prf_port_pkg;

	localparam int prf_n_rename  = 2; // rat1 and rat2, one rename each per cycle
	localparam int prf_n_read    = 4; // opa and opb of both renamed instructions
	localparam int prf_n_cdb     = 2; // two writeback buses, the higher one wins a tie
	localparam int prf_n_release = 2; // one retirement free from each rrat

endpackage

`default_nettype wire

//--- common/prf_geom_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////
// physical register file geometry
////////////////////////////////////////////////////////////////////////

package prf_geom_pkg;

	// every physical entry starts out free after reset
	// there are no reserved architectural entries
	localparam int prf_size = 32;

	// a physical tag as carried by the rename ports, the cdb and the reads
	localparam int prf_idx_w = $clog2(prf_size);

	// one operand as written back by the execution units
	localparam int prf_data_w = 64;

endpackage

`default_nettype wire
